// File: logic/fetch_pkg.sv
// shared types and constants of the instruction fetch stage
// addresses and instruction words are both ADDR_W wide, no compressed support
// mtvec and the boot address must be aligned to 2**VEC_ALIGN_BITS bytes

package fetch_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // widths and fixed addresses
  ////////////////////////////////////////////////////////////////////////////

  localparam int unsigned ADDR_W         = 32;
  localparam int unsigned IRQ_CAUSE_W    = 5;
  localparam int unsigned VEC_ALIGN_BITS = 8;

  // all internal interrupts share the NMI vector
  localparam logic [IRQ_CAUSE_W-1:0] NMI_CAUSE = 5'd31;

  // low byte of the first fetched PC after boot
  localparam logic [VEC_ALIGN_BITS-1:0] BOOT_OFFSET = 8'h80;

  // debug module entry points
  localparam logic [ADDR_W-1:0] DM_HALT_ADDR = 32'h1A110800;
  localparam logic [ADDR_W-1:0] DM_EXC_ADDR  = 32'h1A110808;

  ////////////////////////////////////////////////////////////////////////////
  // selectors and states
  ////////////////////////////////////////////////////////////////////////////

  // next PC source, driven by the controller together with pc_set
  typedef enum logic [2:0] {
    PC_BOOT,
    PC_JUMP,
    PC_EXC,
    PC_ERET,
    PC_DRET
  } pc_sel_e;

  // kind of exception target, only looked at for PC_EXC
  typedef enum logic [1:0] {
    EXC_PC_EXC,
    EXC_PC_IRQ,
    EXC_PC_DBD,
    EXC_PC_DBG_EXC
  } exc_pc_sel_e;

  // bus side of the fetch unit
  typedef enum logic [1:0] {
    FETCH_IDLE,
    FETCH_WAIT_GNT,
    FETCH_WAIT_RVALID
  } fetch_state_e;

endpackage

// File: logic/fetch_target_mux.sv
// next fetch address and exception target, purely combinational
// mtvec is taken as a vector base, its low VEC_ALIGN_BITS bits are ignored
// boot address low byte must be zero, it is replaced by BOOT_OFFSET

module fetch_target_mux
  import fetch_pkg::*;
(
  input  logic                   pc_set_i,
  input  pc_sel_e                pc_mux_i,
  input  exc_pc_sel_e            exc_pc_mux_i,
  input  logic                   irq_int_i,
  input  logic [IRQ_CAUSE_W-1:0] irq_cause_i,
  input  logic [ADDR_W-1:0]      boot_addr_i,
  input  logic [ADDR_W-1:0]      branch_target_i,
  input  logic [ADDR_W-1:0]      csr_mtvec_i,
  input  logic [ADDR_W-1:0]      csr_mepc_i,
  input  logic [ADDR_W-1:0]      csr_depc_i,
  output logic [ADDR_W-1:0]      fetch_addr_n_o,
  output logic                   csr_mtvec_init_o
);

  logic [IRQ_CAUSE_W-1:0]    irq_vec;
  logic [VEC_ALIGN_BITS-1:0] irq_offset;
  logic [ADDR_W-1:0]         mtvec_base;
  logic [ADDR_W-1:0]         boot_pc;
  logic [ADDR_W-1:0]         exc_pc;

  // internal interrupts are routed to the NMI slot
  assign irq_vec = irq_int_i ? NMI_CAUSE : irq_cause_i;

  // one word per vector entry
  assign irq_offset = VEC_ALIGN_BITS'({irq_vec, 2'b00});

  assign mtvec_base = {csr_mtvec_i[ADDR_W-1:VEC_ALIGN_BITS], {VEC_ALIGN_BITS{1'b0}}};
  assign boot_pc    = {boot_addr_i[ADDR_W-1:VEC_ALIGN_BITS], BOOT_OFFSET};

  ////////////////////////////////////////////////////////////////////////////
  // exception target
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : exc_pc_mux
    unique case (exc_pc_mux_i)
      EXC_PC_EXC:     exc_pc = mtvec_base;
      EXC_PC_IRQ:     exc_pc = mtvec_base + ADDR_W'(irq_offset);
      EXC_PC_DBD:     exc_pc = DM_HALT_ADDR;
      EXC_PC_DBG_EXC: exc_pc = DM_EXC_ADDR;
      default:        exc_pc = mtvec_base;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // next fetch address
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin : fetch_addr_mux
    unique case (pc_mux_i)
      PC_BOOT: fetch_addr_n_o = boot_pc;
      PC_JUMP: fetch_addr_n_o = branch_target_i;
      PC_EXC:  fetch_addr_n_o = exc_pc;
      // return paths restore the saved PC
      PC_ERET: fetch_addr_n_o = csr_mepc_i;
      PC_DRET: fetch_addr_n_o = csr_depc_i;
      default: fetch_addr_n_o = boot_pc;
    endcase
  end

  // CSR file sets up mtvec once the core leaves reset
  assign csr_mtvec_init_o = pc_set_i & (pc_mux_i == PC_BOOT);

  // selector and boot address are only meaningful on a redirect
  always_comb begin : target_checks
    if (pc_set_i && (pc_mux_i == PC_EXC)) begin
      assert final (!$isunknown(exc_pc_mux_i))
        else $error("exception target kind is unknown on a redirect");
    end
    if (pc_set_i && (pc_mux_i == PC_BOOT)) begin
      assert final (boot_addr_i[VEC_ALIGN_BITS-1:0] == '0)
        else $error("boot address is not aligned to the vector base");
    end
  end

endmodule

// File: logic/fetch_bus_unit.sv
// single-word fetch unit on a req/gnt/rvalid bus, no prefetch buffer
// relies on the memory granting a new request only after earlier responses
// a redirect drops the held word and any response still in flight

module fetch_bus_unit
  import fetch_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              req_i,
  input  logic              branch_i,
  input  logic [ADDR_W-1:0] branch_addr_i,
  input  logic              fetch_ready_i,
  output logic              fetch_valid_o,
  output logic              fetch_err_o,
  output logic [ADDR_W-1:0] fetch_rdata_o,
  output logic [ADDR_W-1:0] fetch_addr_o,
  output logic              instr_req_o,
  output logic [ADDR_W-1:0] instr_addr_o,
  input  logic              instr_gnt_i,
  input  logic              instr_rvalid_i,
  input  logic              instr_bus_err_i,
  input  logic [ADDR_W-1:0] instr_rdata_i,
  output logic              busy_o
);

  fetch_state_e      state_q, state_d;
  logic [ADDR_W-1:0] req_addr_q, req_addr_d;
  logic [ADDR_W-1:0] next_addr_q, next_addr_d;
  logic              kill_q, kill_d;
  logic              stale_q, stale_d;
  logic              armed_q;
  logic              out_valid_q, out_valid_d;
  logic [ADDR_W-1:0] out_rdata_q;
  logic [ADDR_W-1:0] out_addr_q;
  logic              out_err_q;

  logic              rvalid_cur;
  logic              slot_free;
  logic              go;
  logic              launch;
  logic [ADDR_W-1:0] launch_addr;

  // a response belongs to the current request only once older stale ones are gone
  assign rvalid_cur = instr_rvalid_i & ~stale_q & (state_q == FETCH_WAIT_RVALID);

  // the held word leaves this cycle or is thrown away by the redirect
  assign slot_free = ~out_valid_q | fetch_ready_i | branch_i;

  // nothing goes out before the first redirect
  assign go          = req_i & slot_free & (armed_q | branch_i);
  assign launch_addr = branch_i ? branch_addr_i : next_addr_q;

  ////////////////////////////////////////////////////////////////////////////
  // request FSM
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    state_d     = state_q;
    req_addr_d  = req_addr_q;
    next_addr_d = branch_i ? branch_addr_i : next_addr_q;
    kill_d      = kill_q;
    stale_d     = stale_q & ~instr_rvalid_i;
    launch      = 1'b0;

    unique case (state_q)
      FETCH_IDLE: begin
        launch = go;
      end
      FETCH_WAIT_GNT: begin
        if (instr_gnt_i) begin
          if (kill_q || branch_i) begin
            // granted word is already stale, move on to the target
            stale_d = 1'b1;
            kill_d  = 1'b0;
            state_d = FETCH_IDLE;
            launch  = go;
          end else begin
            state_d = FETCH_WAIT_RVALID;
          end
        end else if (branch_i) begin
          // address must stay put until the grant
          kill_d = 1'b1;
        end
      end
      FETCH_WAIT_RVALID: begin
        if (branch_i) begin
          // response still to come gets dropped
          stale_d = ~rvalid_cur;
          state_d = FETCH_IDLE;
          launch  = go;
        end else if (rvalid_cur) begin
          state_d = FETCH_IDLE;
        end
      end
      default: state_d = FETCH_IDLE;
    endcase

    if (launch) begin
      state_d     = FETCH_WAIT_GNT;
      req_addr_d  = launch_addr;
      next_addr_d = launch_addr + ADDR_W'(4);
    end
  end

  // held word, cleared on accept or redirect
  always_comb begin
    out_valid_d = out_valid_q;
    if (rvalid_cur && !branch_i) begin
      out_valid_d = 1'b1;
    end else if (branch_i || fetch_ready_i) begin
      out_valid_d = 1'b0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q     <= FETCH_IDLE;
      req_addr_q  <= '0;
      next_addr_q <= '0;
      kill_q      <= 1'b0;
      stale_q     <= 1'b0;
      armed_q     <= 1'b0;
      out_valid_q <= 1'b0;
      out_rdata_q <= '0;
      out_addr_q  <= '0;
      out_err_q   <= 1'b0;
    end else begin
      state_q     <= state_d;
      req_addr_q  <= req_addr_d;
      next_addr_q <= next_addr_d;
      kill_q      <= kill_d;
      stale_q     <= stale_d;
      armed_q     <= armed_q | branch_i;
      out_valid_q <= out_valid_d;
      if (rvalid_cur) begin
        out_rdata_q <= instr_rdata_i;
        out_addr_q  <= req_addr_q;
        out_err_q   <= instr_bus_err_i;
      end
    end
  end

  assign instr_req_o  = (state_q == FETCH_WAIT_GNT);
  assign instr_addr_o = req_addr_q;

  // redirect hides the held word at once
  assign fetch_valid_o = out_valid_q & ~branch_i;
  assign fetch_rdata_o = out_rdata_q;
  assign fetch_addr_o  = out_addr_q;
  assign fetch_err_o   = out_err_q;

  assign busy_o = (state_q != FETCH_IDLE) | stale_q;

  ////////////////////////////////////////////////////////////////////////////
  // bus checks
  ////////////////////////////////////////////////////////////////////////////

  // targets from the controller must be word aligned
  addr_aligned_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> (instr_addr_o[1:0] == 2'b00));

  addr_stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !instr_gnt_i |=> instr_req_o && $stable(instr_addr_o));

  // memory answers only granted requests
  no_orphan_rvalid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_rvalid_i |-> (state_q == FETCH_WAIT_RVALID) || stale_q);

endmodule

// File: logic/if_id_regs.sv
// IF-ID pipeline register, all flops reset
// valid is held until the decode stage clears it or a new word replaces it

module if_id_regs
  import fetch_pkg::*;
(
  input  logic              clk_i,
  input  logic              rst_ni,
  input  logic              fetch_valid_i,
  input  logic              fetch_err_i,
  input  logic [ADDR_W-1:0] fetch_rdata_i,
  input  logic [ADDR_W-1:0] fetch_addr_i,
  output logic              fetch_ready_o,
  input  logic              pc_set_i,
  input  logic              id_in_ready_i,
  input  logic              instr_valid_clear_i,
  output logic              instr_valid_id_o,
  output logic              instr_new_id_o,
  output logic              instr_fetch_err_o,
  output logic [ADDR_W-1:0] instr_rdata_id_o,
  output logic [ADDR_W-1:0] pc_id_o
);

  logic pipe_we;
  logic valid_d;

  // decode stage back-pressure goes straight to the fetch unit
  assign fetch_ready_o = id_in_ready_i;

  // load whenever a word is handed over
  assign pipe_we = fetch_valid_i & fetch_ready_o;

  // a word loaded together with a redirect never becomes valid
  assign valid_d = (pipe_we & ~pc_set_i) | (instr_valid_id_o & ~instr_valid_clear_i);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_valid_id_o <= 1'b0;
      instr_new_id_o   <= 1'b0;
    end else begin
      instr_valid_id_o <= valid_d;
      // high for one cycle per loaded word
      instr_new_id_o   <= pipe_we;
    end
  end

  // payload frozen while decode stalls
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      instr_rdata_id_o  <= '0;
      pc_id_o           <= '0;
      instr_fetch_err_o <= 1'b0;
    end else if (pipe_we) begin
      instr_rdata_id_o  <= fetch_rdata_i;
      pc_id_o           <= fetch_addr_i;
      instr_fetch_err_o <= fetch_err_i;
    end
  end

  // new word is only invalid when a redirect squashed it on load
  new_implies_valid_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> instr_valid_id_o || $past(pc_set_i));

endmodule

// File: logic/if_stage.sv
// instruction fetch stage top, 32-bit words only
// issues nothing until the controller redirects to the boot address
// pc_if_o is the address of the word offered to the IF-ID register

module if_stage
  import fetch_pkg::*;
(
  input  logic                   clk_i,
  input  logic                   rst_ni,

  // controller
  input  logic                   req_i,
  input  logic                   pc_set_i,
  input  pc_sel_e                pc_mux_i,
  input  exc_pc_sel_e            exc_pc_mux_i,
  input  logic                   irq_int_i,
  input  logic [IRQ_CAUSE_W-1:0] irq_cause_i,
  input  logic [ADDR_W-1:0]      branch_target_i,
  input  logic [ADDR_W-1:0]      boot_addr_i,

  // CSRs
  input  logic [ADDR_W-1:0]      csr_mtvec_i,
  input  logic [ADDR_W-1:0]      csr_mepc_i,
  input  logic [ADDR_W-1:0]      csr_depc_i,
  output logic                   csr_mtvec_init_o,

  // instruction bus
  output logic                   instr_req_o,
  output logic [ADDR_W-1:0]      instr_addr_o,
  input  logic                   instr_gnt_i,
  input  logic                   instr_rvalid_i,
  input  logic [ADDR_W-1:0]      instr_rdata_i,
  input  logic                   instr_bus_err_i,

  // decode stage
  input  logic                   id_in_ready_i,
  input  logic                   instr_valid_clear_i,
  output logic                   instr_valid_id_o,
  output logic                   instr_new_id_o,
  output logic [ADDR_W-1:0]      instr_rdata_id_o,
  output logic [ADDR_W-1:0]      pc_id_o,
  output logic                   instr_fetch_err_o,

  output logic                   if_busy_o,
  output logic [ADDR_W-1:0]      pc_if_o
);

  logic [ADDR_W-1:0] fetch_addr_n;
  logic              fetch_valid;
  logic              fetch_ready;
  logic [ADDR_W-1:0] fetch_rdata;
  logic [ADDR_W-1:0] fetch_addr;
  logic              fetch_err;

  fetch_target_mux i_fetch_target_mux (
    .pc_set_i         (pc_set_i),
    .pc_mux_i         (pc_mux_i),
    .exc_pc_mux_i     (exc_pc_mux_i),
    .irq_int_i        (irq_int_i),
    .irq_cause_i      (irq_cause_i),
    .boot_addr_i      (boot_addr_i),
    .branch_target_i  (branch_target_i),
    .csr_mtvec_i      (csr_mtvec_i),
    .csr_mepc_i       (csr_mepc_i),
    .csr_depc_i       (csr_depc_i),
    .fetch_addr_n_o   (fetch_addr_n),
    .csr_mtvec_init_o (csr_mtvec_init_o)
  );

  // redirect target is taken on pc_set
  fetch_bus_unit i_fetch_bus_unit (
    .clk_i           (clk_i),
    .rst_ni          (rst_ni),
    .req_i           (req_i),
    .branch_i        (pc_set_i),
    .branch_addr_i   (fetch_addr_n),
    .fetch_ready_i   (fetch_ready),
    .fetch_valid_o   (fetch_valid),
    .fetch_err_o     (fetch_err),
    .fetch_rdata_o   (fetch_rdata),
    .fetch_addr_o    (fetch_addr),
    .instr_req_o     (instr_req_o),
    .instr_addr_o    (instr_addr_o),
    .instr_gnt_i     (instr_gnt_i),
    .instr_rvalid_i  (instr_rvalid_i),
    .instr_bus_err_i (instr_bus_err_i),
    .instr_rdata_i   (instr_rdata_i),
    .busy_o          (if_busy_o)
  );

  if_id_regs i_if_id_regs (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .fetch_valid_i       (fetch_valid),
    .fetch_err_i         (fetch_err),
    .fetch_rdata_i       (fetch_rdata),
    .fetch_addr_i        (fetch_addr),
    .fetch_ready_o       (fetch_ready),
    .pc_set_i            (pc_set_i),
    .id_in_ready_i       (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i),
    .instr_valid_id_o    (instr_valid_id_o),
    .instr_new_id_o      (instr_new_id_o),
    .instr_fetch_err_o   (instr_fetch_err_o),
    .instr_rdata_id_o    (instr_rdata_id_o),
    .pc_id_o             (pc_id_o)
  );

  assign pc_if_o = fetch_addr;

endmodule

// File: testbench/instr_mem_model.sv
// instruction bus responder for the fetch stage testbench
// one outstanding request only, a new grant waits for the previous response
// read data is the word address XOR SCRAMBLE, errors flagged in one 16-byte window

module instr_mem_model #(
  parameter logic [31:0] SCRAMBLE = 32'h5A3C96E1,
  parameter logic [31:0] ERR_BASE = 32'h00006000
) (
  input  logic        clk_i,
  input  logic        rst_ni,
  input  logic        req_i,
  input  logic [31:0] addr_i,
  output logic        gnt_o,
  output logic        rvalid_o,
  output logic [31:0] rdata_o,
  output logic        err_o
);

  // cycles left before the next grant, drawn after every grant
  logic [1:0]  gnt_wait_q;
  // granted request still waiting for its response
  logic        pending_q;
  logic [1:0]  resp_wait_q;
  logic [31:0] resp_addr_q;

  // no grant while a response is still owed
  assign gnt_o    = req_i & ~pending_q & (gnt_wait_q == 2'd0);
  assign rvalid_o = pending_q & (resp_wait_q == 2'd0);
  assign rdata_o  = resp_addr_q ^ SCRAMBLE;

  // error window compares all address bits above the low nibble
  assign err_o = rvalid_o & (resp_addr_q[31:4] == ERR_BASE[31:4]);

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      gnt_wait_q  <= 2'd0;
      pending_q   <= 1'b0;
      resp_wait_q <= 2'd0;
      resp_addr_q <= '0;
    end else begin
      if (gnt_o) begin
        pending_q   <= 1'b1;
        resp_addr_q <= addr_i;
        // response 1 to 3 cycles after the grant
        resp_wait_q <= 2'($urandom_range(0, 2));
        // grant delay 0 to 3 cycles for the next request
        gnt_wait_q  <= 2'($urandom_range(0, 3));
      end else begin
        if (req_i && !pending_q && (gnt_wait_q != 2'd0)) begin
          gnt_wait_q <= gnt_wait_q - 2'd1;
        end
        if (rvalid_o) begin
          pending_q <= 1'b0;
        end else if (pending_q) begin
          resp_wait_q <= resp_wait_q - 2'd1;
        end
      end
    end
  end

endmodule

// File: testbench/tb_if_stage.sv
// testbench for the instruction fetch stage
// decode ready is random except in one held-low stretch
// req_i is high after reset apart from one low stretch around a jump

module tb_if_stage;
  import fetch_pkg::*;

  localparam logic [31:0] SCRAMBLE   = 32'h5A3C96E1;
  localparam logic [31:0] ERR_BASE   = 32'h00006000;
  localparam logic [31:0] ALIGN_MASK = (32'd1 << VEC_ALIGN_BITS) - 32'd1;
  localparam int          WAIT_LIMIT = 300;

  logic clk_i = 1'b0;
  logic rst_ni = 1'b0;
  logic req_i = 1'b0;
  logic pc_set_i = 1'b0;
  pc_sel_e pc_mux_i = PC_BOOT;
  exc_pc_sel_e exc_pc_mux_i = EXC_PC_EXC;
  logic irq_int_i = 1'b0;
  logic [IRQ_CAUSE_W-1:0] irq_cause_i = '0;
  logic [31:0] branch_target_i = '0;
  logic [31:0] boot_addr_i = 32'h00001000;
  logic [31:0] csr_mtvec_i = 32'h00003001;
  logic [31:0] csr_mepc_i = 32'h40000010;
  logic [31:0] csr_depc_i = 32'h50000020;
  logic id_in_ready_i = 1'b0;
  logic instr_valid_clear_i = 1'b0;
  logic instr_req_o;
  logic instr_gnt_i;
  logic instr_rvalid_i;
  logic instr_bus_err_i;
  logic [31:0] instr_addr_o;
  logic [31:0] instr_rdata_i;
  logic csr_mtvec_init_o;
  logic instr_valid_id_o;
  logic instr_new_id_o;
  logic instr_fetch_err_o;
  logic if_busy_o;
  logic [31:0] instr_rdata_id_o;
  logic [31:0] pc_id_o;
  logic [31:0] pc_if_o;

  int errors = 0;
  int tests = 0;
  bit timed_out = 1'b0;
  bit hold_ready = 1'b0;

  always #2 clk_i = ~clk_i;

  if_stage i_if_stage (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (req_i), .pc_set_i (pc_set_i),
    .pc_mux_i (pc_mux_i), .exc_pc_mux_i (exc_pc_mux_i), .irq_int_i (irq_int_i),
    .irq_cause_i (irq_cause_i), .branch_target_i (branch_target_i),
    .boot_addr_i (boot_addr_i), .csr_mtvec_i (csr_mtvec_i), .csr_mepc_i (csr_mepc_i),
    .csr_depc_i (csr_depc_i), .csr_mtvec_init_o (csr_mtvec_init_o),
    .instr_req_o (instr_req_o), .instr_addr_o (instr_addr_o), .instr_gnt_i (instr_gnt_i),
    .instr_rvalid_i (instr_rvalid_i), .instr_rdata_i (instr_rdata_i),
    .instr_bus_err_i (instr_bus_err_i), .id_in_ready_i (id_in_ready_i),
    .instr_valid_clear_i (instr_valid_clear_i), .instr_valid_id_o (instr_valid_id_o),
    .instr_new_id_o (instr_new_id_o), .instr_rdata_id_o (instr_rdata_id_o),
    .pc_id_o (pc_id_o), .instr_fetch_err_o (instr_fetch_err_o),
    .if_busy_o (if_busy_o), .pc_if_o (pc_if_o)
  );

  instr_mem_model #(.SCRAMBLE (SCRAMBLE), .ERR_BASE (ERR_BASE)) i_instr_mem_model (
    .clk_i (clk_i), .rst_ni (rst_ni), .req_i (instr_req_o), .addr_i (instr_addr_o),
    .gnt_o (instr_gnt_i), .rvalid_o (instr_rvalid_i), .rdata_o (instr_rdata_i),
    .err_o (instr_bus_err_i)
  );

  // expected redirect target, straight from the address rules of the stage
  function automatic logic [31:0] predict_target(input pc_sel_e sel, input exc_pc_sel_e exc,
                                                 input logic irq_int, input logic [4:0] cause);
    logic [31:0] base;
    logic [31:0] vec;
    base = csr_mtvec_i & ~ALIGN_MASK;
    vec  = irq_int ? 32'(NMI_CAUSE) : 32'(cause);
    case (sel)
      PC_BOOT: return (boot_addr_i & ~ALIGN_MASK) | 32'(BOOT_OFFSET);
      PC_JUMP: return branch_target_i;
      PC_ERET: return csr_mepc_i;
      PC_DRET: return csr_depc_i;
      default: begin
        case (exc)
          EXC_PC_EXC: return base;
          EXC_PC_IRQ: return base + vec * 32'd4;
          EXC_PC_DBD: return DM_HALT_ADDR;
          default:    return DM_EXC_ADDR;
        endcase
      end
    endcase
  endfunction

  function automatic logic in_window(input logic [31:0] addr);
    return addr[31:4] == ERR_BASE[31:4];
  endfunction

  // wrong value on a named signal
  task automatic report_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] exp);
    errors++;
    $display("Error %0t %s: got %0h expected %0h", $time, sig, got, exp);
  endtask

  task automatic report_failure(input string what);
    errors++;
    $display("%0t %s", $time, what);
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // decode side driver
  ////////////////////////////////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (hold_ready) begin
      id_in_ready_i       <= 1'b0;
      instr_valid_clear_i <= ($urandom_range(0, 1) == 0);
    end else begin
      id_in_ready_i       <= ($urandom_range(0, 3) != 0);
      instr_valid_clear_i <= ($urandom_range(0, 3) == 0);
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reference state for the checks
  ////////////////////////////////////////////////////////////////////////////

  logic        new_word;
  logic        redirect_pending;
  logic        have_last;
  logic        seen_redirect;
  logic        prev_ready;
  logic        prev_clear;
  logic        prev_wait;
  logic        prev_req;
  logic        prev_instr_req;
  logic [31:0] redirect_target;
  logic [31:0] last_pc;
  logic [31:0] prev_pc;
  logic [31:0] prev_rdata;
  logic [31:0] prev_addr;
  logic [31:0] prev_pc_if;

  assign new_word = instr_new_id_o & instr_valid_id_o;

  always @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      redirect_pending <= 1'b0;
      redirect_target  <= '0;
      have_last        <= 1'b0;
      seen_redirect    <= 1'b0;
      last_pc          <= '0;
      prev_ready       <= 1'b1;
      prev_clear       <= 1'b0;
      prev_pc          <= '0;
      prev_rdata       <= '0;
      prev_wait        <= 1'b0;
      prev_addr        <= '0;
      prev_req         <= 1'b0;
      prev_instr_req   <= 1'b0;
      prev_pc_if       <= '0;
    end else begin
      if (pc_set_i) begin
        redirect_pending <= 1'b1;
        redirect_target  <= predict_target(pc_mux_i, exc_pc_mux_i, irq_int_i, irq_cause_i);
        have_last        <= 1'b0;
        seen_redirect    <= 1'b1;
      end else if (new_word) begin
        redirect_pending <= 1'b0;
        have_last        <= 1'b1;
        last_pc          <= pc_id_o;
      end
      prev_ready     <= id_in_ready_i;
      prev_clear     <= instr_valid_clear_i;
      prev_pc        <= pc_id_o;
      prev_rdata     <= instr_rdata_id_o;
      prev_wait      <= instr_req_o & ~instr_gnt_i;
      prev_addr      <= instr_addr_o;
      prev_req       <= req_i;
      prev_instr_req <= instr_req_o;
      prev_pc_if     <= pc_if_o;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // checks
  ////////////////////////////////////////////////////////////////////////////

  target_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    new_word && redirect_pending |-> pc_id_o == redirect_target)
    else report_mismatch("pc_id_o", $sampled(pc_id_o), $sampled(redirect_target));
  seq_pc_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    new_word && !redirect_pending && have_last |-> pc_id_o == last_pc + 32'd4)
    else report_mismatch("pc_id_o", $sampled(pc_id_o), $sampled(last_pc) + 32'd4);
  rdata_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    new_word |-> instr_rdata_id_o == (pc_id_o ^ SCRAMBLE))
    else report_mismatch("instr_rdata_id_o", $sampled(instr_rdata_id_o),
                         $sampled(pc_id_o) ^ SCRAMBLE);
  // the word offered at the transfer is the one that lands in decode
  pc_if_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_new_id_o |-> pc_id_o == prev_pc_if)
    else report_mismatch("pc_if_o", $sampled(prev_pc_if), $sampled(pc_id_o));
  align_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> instr_addr_o[1:0] == 2'b00)
    else report_mismatch("instr_addr_o[1:0]", 32'($sampled(instr_addr_o[1:0])), 32'd0);
  stable_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_wait |-> instr_req_o && instr_addr_o == prev_addr)
    else report_mismatch("instr_addr_o", $sampled(instr_addr_o), $sampled(prev_addr));
  req_gate_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o && !prev_instr_req |-> prev_req)
    else report_failure("a bus request started while req_i was low");
  // idle until the first redirect, busy while a request waits
  busy_idle_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !seen_redirect |-> !if_busy_o)
    else report_mismatch("if_busy_o", 32'($sampled(if_busy_o)), 32'd0);
  busy_req_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_req_o |-> if_busy_o)
    else report_mismatch("if_busy_o", 32'($sampled(if_busy_o)), 32'd1);
  err_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    new_word |-> instr_fetch_err_o == in_window(pc_id_o))
    else report_mismatch("instr_fetch_err_o", 32'($sampled(instr_fetch_err_o)),
                         32'(in_window($sampled(pc_id_o))));
  hold_new_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !prev_ready |-> !instr_new_id_o)
    else report_mismatch("instr_new_id_o", 32'($sampled(instr_new_id_o)), 32'd0);
  hold_pc_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !prev_ready |-> pc_id_o == prev_pc)
    else report_mismatch("pc_id_o", $sampled(pc_id_o), $sampled(prev_pc));
  hold_rdata_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    !prev_ready |-> instr_rdata_id_o == prev_rdata)
    else report_mismatch("instr_rdata_id_o", $sampled(instr_rdata_id_o),
                         $sampled(prev_rdata));
  clear_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    prev_clear && !prev_ready |-> !instr_valid_id_o)
    else report_mismatch("instr_valid_id_o", 32'($sampled(instr_valid_id_o)), 32'd0);
  mtvec_a : assert property (@(posedge clk_i) disable iff (!rst_ni)
    csr_mtvec_init_o == (pc_set_i && pc_mux_i == PC_BOOT))
    else report_mismatch("csr_mtvec_init_o", 32'($sampled(csr_mtvec_init_o)),
                         32'($sampled(pc_set_i && pc_mux_i == PC_BOOT)));

  ////////////////////////////////////////////////////////////////////////////
  // sequences
  ////////////////////////////////////////////////////////////////////////////

  task automatic redirect(input pc_sel_e sel, input exc_pc_sel_e exc, input logic irq_int,
                          input logic [4:0] cause, input logic [31:0] target);
    @(posedge clk_i);
    pc_mux_i        <= sel;
    exc_pc_mux_i    <= exc;
    irq_int_i       <= irq_int;
    irq_cause_i     <= cause;
    branch_target_i <= target;
    pc_set_i        <= 1'b1;
    @(posedge clk_i);
    pc_set_i <= 1'b0;
  endtask

  // counts words reaching decode, gives up after WAIT_LIMIT cycles
  task automatic wait_words(input int n);
    int seen;
    int cycles;
    seen   = 0;
    cycles = 0;
    while (seen < n && !timed_out) begin
      @(posedge clk_i);
      if (new_word) seen++;
      cycles++;
      if (cycles > WAIT_LIMIT) begin
        $display("timeout: only %0d of %0d words reached decode", seen, n);
        timed_out = 1'b1;
      end
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    $display("%-14s %0d errors%s", name, errors - err_before, timed_out ? ", timed out" : "");
  endtask

  initial begin
    int e;
    void'($urandom(13));
    repeat (16) @(posedge clk_i);
    rst_ni <= 1'b1;
    req_i  <= 1'b1;
    repeat (2) @(posedge clk_i);

    e = errors;
    redirect(PC_BOOT, EXC_PC_EXC, 1'b0, 5'd0, 32'h0);
    wait_words(6);
    report_test("boot", e);

    // second jump lands while the first one is still in flight
    e = errors;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h00002000);
    repeat (2) @(posedge clk_i);
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h00002400);
    wait_words(6);
    report_test("jumps", e);

    e = errors;
    redirect(PC_EXC, EXC_PC_EXC, 1'b0, 5'd0, 32'h0);
    wait_words(3);
    redirect(PC_EXC, EXC_PC_IRQ, 1'b0, 5'd5, 32'h0);
    wait_words(3);
    redirect(PC_EXC, EXC_PC_IRQ, 1'b1, 5'd3, 32'h0);
    wait_words(3);
    redirect(PC_EXC, EXC_PC_DBD, 1'b0, 5'd0, 32'h0);
    wait_words(3);
    redirect(PC_EXC, EXC_PC_DBG_EXC, 1'b0, 5'd0, 32'h0);
    wait_words(3);
    report_test("exceptions", e);

    e = errors;
    redirect(PC_ERET, EXC_PC_EXC, 1'b0, 5'd0, 32'h0);
    wait_words(3);
    redirect(PC_DRET, EXC_PC_EXC, 1'b0, 5'd0, 32'h0);
    wait_words(3);
    report_test("returns", e);

    // walks across the whole error window
    e = errors;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h00005FF8);
    wait_words(8);
    report_test("bus error", e);

    e = errors;
    hold_ready <= 1'b1;
    repeat (20) @(posedge clk_i);
    hold_ready <= 1'b0;
    wait_words(4);
    report_test("ready low", e);

    // jump taken while req_i is low, fetch resumes at the target once it rises
    e = errors;
    req_i <= 1'b0;
    redirect(PC_JUMP, EXC_PC_EXC, 1'b0, 5'd0, 32'h00007000);
    repeat (10) @(posedge clk_i);
    req_i <= 1'b1;
    wait_words(3);
    report_test("req low", e);

    $display("tests run %0d, checks failed %0d", tests, errors);
    if (errors == 0 && !timed_out) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

// File: src.f
logic/fetch_pkg.sv
logic/fetch_target_mux.sv
logic/fetch_bus_unit.sv
logic/if_id_regs.sv
logic/if_stage.sv
testbench/instr_mem_model.sv
testbench/tb_if_stage.sv

// File: Makefile
# Verilator build and run of the fetch stage testbench

VERILATOR ?= verilator
TOP       := tb_if_stage
FILELIST  := src.f
OBJ_DIR   := obj_dir
FLAGS     := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

# pass or fail comes from the pass line in the output
run: build
	./$(OBJ_DIR)/V$(TOP) | tee /dev/stderr | grep -q '^\*\* PASS \*\*$$'

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
